// ==== files.f ====
wfd_pkg.sv
burst_counter.sv
fill_counter.sv
delay_tap_reset.sv
acq_controller.sv
register_block.sv
channel_top.sv
tb_channel.sv

// ==== run.sh ====
#!/bin/sh
# build and run the channel testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_channel \
	-f files.f -o sim_channel > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_channel > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== tb_channel.sv ====
//////////////////////////////////////////////////
// Digitizer channel testbench
// reference model of registers, fills and delay reset,
// compared with the DUT by assertions on every rising edge
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_channel;
	import wfd_pkg::*;

	localparam int NUM_LANES          = 13;
	localparam int DELAY_RESET_CYCLES = 4;
	localparam int CLK_PERIOD         = 4;
	localparam int NUM_FILLS          = 7;
	localparam int MAX_FILL_CYCLES    = 40;  // setup writes, longest fill and drain
	localparam int HOST_OPS           = 80;
	localparam int OP_CYCLES          = 4;   // one register read
	localparam int WATCHDOG_CYCLES    = NUM_FILLS*MAX_FILL_CYCLES + HOST_OPS*OP_CYCLES + 200;

	logic                       clk;
	logic                       reset;
	logic                       cnt_reset;
	logic [DATA_W-1:0]          rx_data;
	logic [DATA_W-1:0]          tx_data;
	logic                       reg_num_le;
	logic                       wr_en;
	logic                       rd_en;
	logic                       illegal_reg_num;
	logic [2:0]                 ch_addr;
	logic                       trigger;
	fill_type_e                 fill_type;
	logic [NUM_LANES*TAP_W-1:0] current_taps;
	logic                       delay_data_reset;
	logic [TAP_W-1:0]           delay_tap;
	logic                       busy;
	logic                       burst_strobe;
	logic [FILL_NUM_W-1:0]      fill_num;
	logic [15:0]                channel_tag;
	logic [DATA_W-1:0]          genreg_addr_ctrl;
	logic [DATA_W-1:0]          genreg_wr_data;
	logic [DATA_W-1:0]          genreg_rd_data;

	logic [DATA_W-1:0]     m_regs [32];  // model register file
	logic [DATA_W-1:0]     m_num;        // latched register number
	logic [DATA_W-1:0]     m_tx;
	logic [FILL_NUM_W-1:0] m_fill;
	logic                  m_err;        // expected delay error flag
	logic                  m_drr_start;  // tap changed on the last edge
	int                    m_drr_left;
	logic [2:0]            sched [$];    // per cycle {fill_done, busy, burst_strobe}
	logic                  fill_check;   // off while a register 0 reload settles
	int                    strobe_cnt;
	int                    mismatches;
	int                    other_errors;
	integer                seed;

	channel_top #(
		.NUM_LANES(NUM_LANES),
		.DELAY_RESET_CYCLES(DELAY_RESET_CYCLES)
	) u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	function automatic void report_mismatch(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		mismatches++;
		$display("Mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
	endfunction

	// readback word by the register map with narrow fields zero extended
	function automatic logic [DATA_W-1:0] expected_readback(input logic [REG_ADDR_W-1:0] r);
		case (r)
			REG_FILL_NUM:      return 32'(m_fill);        // live count
			REG_CHAN_TAG:      return {16'h0, m_regs[r][15:3], ch_addr};
			REG_MUON_BURSTS, REG_LASER_BURSTS, REG_PED_BURSTS:
				return {9'h0, m_regs[r][BURST_W-1:0]};
			REG_GENREG_RDATA:  return genreg_rd_data;
			REG_DELAY_TAP:     return {27'h0, m_regs[r][TAP_W-1:0]};
			REG_CUR_TAP_LO:    return {7'h0, current_taps[24:0]};  // lanes 0 to 4
			REG_CUR_TAP_MID:   return {7'h0, current_taps[49:25]};
			REG_CUR_TAP_HI:    return {17'h0, current_taps[64:50]}; // lanes 10 to 12
			REG_DELAY_ERR:     return {31'h0, m_err};
			REG_NUM_WAVEFORMS: return {20'h0, m_regs[r][WAVEFORM_W-1:0]};
			REG_WAVEFORM_GAP:  return {10'h0, m_regs[r][GAP_W-1:0]};
			default:           return m_regs[r];
		endcase
	endfunction

	function automatic void write_model(input logic [REG_ADDR_W-1:0] r,
		input logic [DATA_W-1:0] d);
		if (r == REG_GENREG_RDATA || (r >= REG_CUR_TAP_LO && r <= REG_DELAY_ERR))
			return; // status registers
		if (r == REG_DELAY_TAP && d[TAP_W-1:0] != m_regs[REG_DELAY_TAP][TAP_W-1:0])
			m_drr_start = 1'b1;
		m_regs[r] = d;
	endfunction

	// expected cycles of one fill from the cycle after the trigger
	function automatic void schedule_fill();
		int bursts;
		int wf;
		int gap;
		case (fill_type)
			FILL_MUON:  bursts = int'(m_regs[REG_MUON_BURSTS][BURST_W-1:0]);
			FILL_LASER: bursts = int'(m_regs[REG_LASER_BURSTS][BURST_W-1:0]);
			FILL_PED:   bursts = int'(m_regs[REG_PED_BURSTS][BURST_W-1:0]);
			default:    bursts = 0;
		endcase
		wf  = int'(m_regs[REG_NUM_WAVEFORMS][WAVEFORM_W-1:0]);
		gap = int'(m_regs[REG_WAVEFORM_GAP][GAP_W-1:0]);
		if (bursts != 0) begin
			for (int w = 0; w < wf; w++) begin
				for (int b = 0; b < bursts; b++)
					sched.push_back(3'b011);
				if (w != wf - 1)
					for (int g = 0; g < gap; g++)
						sched.push_back(3'b010); // dead time
			end
		end
		sched.push_back(3'b110); // fill_done cycle while still busy
	endfunction

	function automatic void check_outputs(input logic [2:0] slot);
		assert (busy == slot[1]) else report_mismatch("busy", 32'(busy), 32'(slot[1]));
		assert (burst_strobe == slot[0])
			else report_mismatch("burst_strobe", 32'(burst_strobe), 32'(slot[0]));
		assert (tx_data == m_tx) else report_mismatch("tx_data", tx_data, m_tx);
		assert (illegal_reg_num == (|m_num[DATA_W-1:REG_ADDR_W]))
			else report_mismatch("illegal_reg_num", 32'(illegal_reg_num),
				32'(|m_num[DATA_W-1:REG_ADDR_W]));
		assert (delay_tap == m_regs[REG_DELAY_TAP][TAP_W-1:0])
			else report_mismatch("delay_tap", 32'(delay_tap), m_regs[REG_DELAY_TAP]);
		assert (delay_data_reset == (m_drr_left != 0))
			else report_mismatch("delay_data_reset", 32'(delay_data_reset),
				32'(m_drr_left != 0));
		assert (channel_tag == {m_regs[REG_CHAN_TAG][15:3], ch_addr})
			else report_mismatch("channel_tag", 32'(channel_tag),
				32'({m_regs[REG_CHAN_TAG][15:3], ch_addr}));
		assert (genreg_addr_ctrl == m_regs[REG_GENREG_ADDR])
			else report_mismatch("genreg_addr_ctrl", genreg_addr_ctrl, m_regs[REG_GENREG_ADDR]);
		assert (genreg_wr_data == m_regs[REG_GENREG_WDATA])
			else report_mismatch("genreg_wr_data", genreg_wr_data, m_regs[REG_GENREG_WDATA]);
		if (fill_check) begin
			assert (fill_num == m_fill)
				else report_mismatch("fill_num", 32'(fill_num), 32'(m_fill));
		end
	endfunction

	// model sees the same edge as the DUT with inputs set on the falling edge
	always @(posedge clk) begin : model
		logic [2:0] slot;
		logic       idle;
		if (reset) begin
			for (int i = 0; i < 32; i++)
				m_regs[i] = '0;
			m_regs[REG_FILL_NUM]      = DEF_FILL_NUM;
			m_regs[REG_MUON_BURSTS]   = DEF_MUON_BURSTS;
			m_regs[REG_DELAY_TAP]     = DEF_DELAY_TAP;
			m_regs[REG_NUM_WAVEFORMS] = DEF_NUM_WAVEFORMS;
			m_num       = '0;
			m_tx        = '0;
			m_fill      = FILL_NUM_W'(DEF_FILL_NUM);
			m_err       = 1'b0;
			m_drr_start = 1'b0;
			m_drr_left  = 0;
			sched.delete();
		end else begin
			idle = (sched.size() == 0);
			slot = idle ? 3'b000 : sched.pop_front();
			check_outputs(slot);
			if (burst_strobe)
				strobe_cnt++;
			if (rd_en)
				m_tx = expected_readback(m_num[REG_ADDR_W-1:0]); // old values on this edge
			if (cnt_reset)
				m_fill = m_regs[REG_FILL_NUM][FILL_NUM_W-1:0]; // load wins over the increment
			else if (slot[2])
				m_fill = m_fill + 1'b1;
			if (m_drr_start) begin
				m_drr_left  = DELAY_RESET_CYCLES; // pulse starts one cycle after the change
				m_drr_start = 1'b0;
			end else if (m_drr_left != 0) begin
				m_drr_left--;
			end
			if (idle && trigger)
				schedule_fill();                  // triggers while busy are dropped
			if (wr_en)
				write_model(m_num[REG_ADDR_W-1:0], rx_data);
			if (reg_num_le)
				m_num = rx_data;
		end
	end

	task automatic select_reg(input logic [DATA_W-1:0] num);
		@(negedge clk);
		reg_num_le = 1'b1;
		rx_data    = num;
		@(negedge clk);
		reg_num_le = 1'b0;
	endtask

	task automatic write_reg(input logic [DATA_W-1:0] num, input logic [DATA_W-1:0] data);
		select_reg(num);
		wr_en   = 1'b1;
		rx_data = data;
		@(negedge clk);
		wr_en = 1'b0;
	endtask

	task automatic read_reg(input logic [DATA_W-1:0] num);
		select_reg(num);
		rd_en = 1'b1;
		@(negedge clk);
		rd_en = 1'b0;
		@(negedge clk); // tx_data compared on the edge just passed
	endtask

	task automatic run_fill(input fill_type_e t, input int bursts, input int wf, input int gap);
		int guard;
		write_reg(32'(REG_MUON_BURSTS) + 32'(t), 32'(bursts));
		write_reg(32'(REG_NUM_WAVEFORMS), 32'(wf));
		write_reg(32'(REG_WAVEFORM_GAP), 32'(gap));
		@(negedge clk);
		fill_type  = t;
		trigger    = 1'b1;
		strobe_cnt = 0;
		@(negedge clk);
		@(negedge clk);                   // second trigger cycle lands while busy
		trigger   = 1'b0;
		fill_type = (t == FILL_MUON) ? FILL_LASER : FILL_MUON; // type moves under a running fill
		guard     = 0;
		while (busy && guard < MAX_FILL_CYCLES) begin
			@(negedge clk);
			guard++;
		end
		if (busy) begin
			other_errors++;
			$display("fill of type %0d did not end, busy still high", t);
		end
		assert (strobe_cnt == bursts * wf)
			else report_mismatch("burst_strobe cycles", 32'(strobe_cnt), 32'(bursts * wf));
	endtask

	task automatic reload_fill(input logic [FILL_NUM_W-1:0] value);
		fill_check = 1'b0;
		write_reg(32'(REG_FILL_NUM), 32'(value));
		repeat (2) @(negedge clk);        // counter reloads shortly after the write
		m_fill     = value;
		fill_check = 1'b1;
	endtask

	task automatic wait_delay_pulse();
		int guard;
		guard = 0;
		while (!delay_data_reset && guard < 10) begin
			@(negedge clk);
			guard++;
		end
		if (!delay_data_reset) begin
			other_errors++;
			$display("delay_data_reset never rose after a tap change");
		end
		guard = 0;
		while (delay_data_reset && guard < 2 * DELAY_RESET_CYCLES) begin
			@(negedge clk);
			guard++;
		end
		if (delay_data_reset) begin
			other_errors++;
			$display("delay_data_reset stayed high");
		end
		repeat (2) @(negedge clk);        // error flag settles
	endtask

	initial begin : stimulus
		int                r;
		int                narrow [5];
		logic [DATA_W-1:0] d;
		seed           = 32'h47f3;
		mismatches     = 0;
		other_errors   = 0;
		fill_check     = 1'b1;
		strobe_cnt     = 0;
		narrow         = '{2, 3, 4, 14, 15};
		reset          = 1'b1;
		cnt_reset      = 1'b0;
		rx_data        = '0;
		reg_num_le     = 1'b0;
		wr_en          = 1'b0;
		rd_en          = 1'b0;
		ch_addr        = 3'b101;
		trigger        = 1'b0;
		fill_type      = FILL_MUON;
		current_taps   = {NUM_LANES{5'd14}};
		genreg_rd_data = 32'h5a5a_0f0f;
		repeat (2) @(negedge clk);
		reset = 1'b0;

		read_reg(32'(REG_FILL_NUM));      // defaults
		read_reg(32'(REG_MUON_BURSTS));
		read_reg(32'(REG_DELAY_TAP));
		read_reg(32'(REG_NUM_WAVEFORMS));

		for (int i = 0; i < 12; i++) begin
			r = (i % 4 == 0) ? 13 : 16 + int'($unsigned($random(seed)) % 16);
			d = $random(seed);
			write_reg(32'(r), d);
			read_reg(32'(r));
		end
		write_reg(32'(REG_GENREG_RDATA), $random(seed)); // read only
		read_reg(32'(REG_GENREG_RDATA));
		write_reg(32'(REG_CHAN_TAG), $random(seed));
		read_reg(32'(REG_CHAN_TAG));
		ch_addr = 3'b010;                 // jumpers move under the tag
		read_reg(32'(REG_CHAN_TAG));
		for (int i = 0; i < 5; i++) begin
			write_reg(32'(narrow[i]), $random(seed));
			read_reg(32'(narrow[i]));
		end
		write_reg(32'(REG_GENREG_ADDR), $random(seed));
		write_reg(32'(REG_GENREG_WDATA), $random(seed));
		select_reg(32'h8000_0003);        // upper bits set
		select_reg(32'h0000_0040);
		read_reg(32'(REG_GENREG_WDATA));

		run_fill(FILL_MUON, 5, 3, 4);
		run_fill(FILL_LASER, 3, 2, 0);
		run_fill(FILL_PED, 1, 4, 1);
		reload_fill(24'h00abcd);
		run_fill(FILL_MUON, 7, 1, 2);
		@(negedge clk);
		cnt_reset = 1'b1;
		@(negedge clk);
		cnt_reset = 1'b0;
		read_reg(32'(REG_FILL_NUM));
		run_fill(FILL_LASER, 0, 2, 3);    // no bursts
		run_fill(FILL_PED, 2, 0, 1);      // no waveforms
		read_reg(32'(REG_FILL_NUM));

		current_taps = {NUM_LANES{5'd9}}; // every lane follows
		write_reg(32'(REG_DELAY_TAP), 32'd9);
		wait_delay_pulse();
		m_err = 1'b0;
		read_reg(32'(REG_DELAY_ERR));
		current_taps = {NUM_LANES{5'd21}};
		current_taps[7*TAP_W +: TAP_W] = 5'd20; // lane 7 lags
		write_reg(32'(REG_DELAY_TAP), 32'd21);
		wait_delay_pulse();
		m_err = 1'b1;
		read_reg(32'(REG_DELAY_ERR));
		for (int i = 9; i <= 11; i++)
			read_reg(32'(i));

		repeat (2) @(negedge clk);
		$display("closing count: %0d mismatches, %0d other errors", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout after %0d cycles, %0d mismatches and %0d other errors so far",
			WATCHDOG_CYCLES, mismatches, other_errors);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== channel_top.sv ====
//////////////////////////////////////////////////
// Digitizer channel core
// register block, acquisition control and delay-tap check
//////////////////////////////////////////////////
`timescale 1ns/1ps

module channel_top #(
	parameter int NUM_LANES          = 13,
	parameter int DELAY_RESET_CYCLES = 4
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                cnt_reset,
	input  logic [wfd_pkg::DATA_W-1:0]          rx_data,
	output logic [wfd_pkg::DATA_W-1:0]          tx_data,
	input  logic                                reg_num_le,
	input  logic                                wr_en,
	input  logic                                rd_en,
	output logic                                illegal_reg_num,
	input  logic [2:0]                          ch_addr,
	input  logic                                trigger,
	input  wfd_pkg::fill_type_e                 fill_type,
	input  logic [NUM_LANES*wfd_pkg::TAP_W-1:0] current_taps,
	output logic                                delay_data_reset,
	output logic [wfd_pkg::TAP_W-1:0]           delay_tap,
	output logic                                busy,
	output logic                                burst_strobe,
	output logic [wfd_pkg::FILL_NUM_W-1:0]      fill_num,
	output logic [15:0]                         channel_tag,
	output logic [wfd_pkg::DATA_W-1:0]          genreg_addr_ctrl,
	output logic [wfd_pkg::DATA_W-1:0]          genreg_wr_data,
	input  logic [wfd_pkg::DATA_W-1:0]          genreg_rd_data
);
	import wfd_pkg::*;

	logic [BURST_W-1:0]    num_muon_bursts;
	logic [BURST_W-1:0]    num_laser_bursts;
	logic [BURST_W-1:0]    num_ped_bursts;
	logic [WAVEFORM_W-1:0] num_waveforms;
	logic [GAP_W-1:0]      waveform_gap;
	logic [FILL_NUM_W-1:0] initial_fill_num;
	logic                  initial_fill_num_wr;
	logic                  delay_error;
	logic [BURST_W-1:0]    burst_count;      // count of the running fill type
	logic                  load_waveform;
	logic                  start_gap;
	logic                  burst_last;
	logic                  gap_last;
	logic                  fill_done;

	register_block #(.NUM_LANES(NUM_LANES)) u_regs (
		.clk(clk), .reset(reset), .cnt_reset(cnt_reset),
		.rx_data(rx_data), .tx_data(tx_data),
		.reg_num_le(reg_num_le), .wr_en(wr_en), .rd_en(rd_en),
		.illegal_reg_num(illegal_reg_num),
		.fill_num(fill_num), .ch_addr(ch_addr), .channel_tag(channel_tag),
		.num_muon_bursts(num_muon_bursts), .num_laser_bursts(num_laser_bursts),
		.num_ped_bursts(num_ped_bursts),
		.num_waveforms(num_waveforms), .waveform_gap(waveform_gap),
		.initial_fill_num(initial_fill_num), .initial_fill_num_wr(initial_fill_num_wr),
		.delay_tap(delay_tap), .current_taps(current_taps), .delay_error(delay_error),
		.genreg_addr_ctrl(genreg_addr_ctrl), .genreg_wr_data(genreg_wr_data),
		.genreg_rd_data(genreg_rd_data)
	);

	acq_controller u_acq (
		.clk(clk), .reset(reset),
		.trigger(trigger), .fill_type(fill_type),
		.num_muon_bursts(num_muon_bursts), .num_laser_bursts(num_laser_bursts),
		.num_ped_bursts(num_ped_bursts),
		.num_waveforms(num_waveforms), .waveform_gap(waveform_gap),
		.burst_last(burst_last), .gap_last(gap_last),
		.load_waveform(load_waveform), .start_gap(start_gap),
		.burst_strobe(burst_strobe), .busy(busy), .fill_done(fill_done),
		.burst_count(burst_count)
	);

	burst_counter u_bursts (
		.clk(clk), .reset(reset),
		.burst_count(burst_count), .waveform_gap(waveform_gap),
		.load_waveform(load_waveform), .start_gap(start_gap),
		.burst_last(burst_last), .gap_last(gap_last)
	);

	fill_counter u_fill (
		.clk(clk), .reset(reset),
		.initial_fill_num(initial_fill_num), .initial_fill_num_wr(initial_fill_num_wr),
		.fill_done(fill_done), .fill_num(fill_num)
	);

	delay_tap_reset #(
		.NUM_LANES(NUM_LANES),
		.DELAY_RESET_CYCLES(DELAY_RESET_CYCLES)
	) u_delay (
		.clk(clk), .reset(reset),
		.delay_tap(delay_tap), .current_taps(current_taps),
		.delay_data_reset(delay_data_reset), .delay_error(delay_error)
	);

endmodule

// ==== register_block.sv ====
//////////////////////////////////////////////////
// Channel register block
// register number latch, 32 x 32 register file, write decode
// and registered readback of settings and live status
//////////////////////////////////////////////////
`timescale 1ns/1ps

module register_block #(
	parameter int NUM_LANES = 13
) (
	input  logic                                      clk,
	input  logic                                      reset,
	input  logic                                      cnt_reset,       // fill number reload
	input  logic [wfd_pkg::DATA_W-1:0]                rx_data,
	output logic [wfd_pkg::DATA_W-1:0]                tx_data,
	input  logic                                      reg_num_le,
	input  logic                                      wr_en,
	input  logic                                      rd_en,
	output logic                                      illegal_reg_num,
	input  logic [wfd_pkg::FILL_NUM_W-1:0]            fill_num,        // live count
	input  logic [2:0]                                ch_addr,         // address jumpers
	output logic [15:0]                               channel_tag,
	output logic [wfd_pkg::BURST_W-1:0]               num_muon_bursts,
	output logic [wfd_pkg::BURST_W-1:0]               num_laser_bursts,
	output logic [wfd_pkg::BURST_W-1:0]               num_ped_bursts,
	output logic [wfd_pkg::WAVEFORM_W-1:0]            num_waveforms,
	output logic [wfd_pkg::GAP_W-1:0]                 waveform_gap,
	output logic [wfd_pkg::FILL_NUM_W-1:0]            initial_fill_num,
	output logic                                      initial_fill_num_wr,
	output logic [wfd_pkg::TAP_W-1:0]                 delay_tap,
	input  logic [NUM_LANES*wfd_pkg::TAP_W-1:0]       current_taps,
	input  logic                                      delay_error,
	output logic [wfd_pkg::DATA_W-1:0]                genreg_addr_ctrl,
	output logic [wfd_pkg::DATA_W-1:0]                genreg_wr_data,
	input  logic [wfd_pkg::DATA_W-1:0]                genreg_rd_data
);
	import wfd_pkg::*;

	localparam int TAPS_PAD_W = 75; // three 25-bit tap slices

	logic [DATA_W-1:0]     reg_num;                 // whole word kept for the illegal check
	logic [REG_ADDR_W-1:0] sel;
	logic [DATA_W-1:0]     regs [2**REG_ADDR_W];
	logic                  wr_ok;                   // write to a writable register
	logic                  fill_wr_q;
	logic [DATA_W-1:0]     rd_value;
	logic [TAPS_PAD_W-1:0] taps_ext;

	always_ff @(posedge clk) begin
		if (reset)
			reg_num <= '0;
		else if (reg_num_le)
			reg_num <= rx_data;
	end

	assign sel             = reg_num[REG_ADDR_W-1:0];
	assign illegal_reg_num = |reg_num[DATA_W-1:REG_ADDR_W]; // only 32 registers exist

	// status registers take no host writes
	assign wr_ok = wr_en && !(sel inside {REG_GENREG_RDATA, REG_CUR_TAP_LO,
		REG_CUR_TAP_MID, REG_CUR_TAP_HI, REG_DELAY_ERR});

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**REG_ADDR_W; i++)
				regs[i] <= '0;
			regs[REG_FILL_NUM]      <= DEF_FILL_NUM;
			regs[REG_MUON_BURSTS]   <= DEF_MUON_BURSTS;
			regs[REG_DELAY_TAP]     <= DEF_DELAY_TAP;
			regs[REG_NUM_WAVEFORMS] <= DEF_NUM_WAVEFORMS;
		end else if (wr_ok) begin
			regs[sel] <= rx_data;
		end
	end

	// reload strobe waits a cycle so the counter sees the new R0
	always_ff @(posedge clk) begin
		if (reset)
			fill_wr_q <= 1'b0;
		else
			fill_wr_q <= wr_en && (sel == REG_FILL_NUM);
	end

	assign initial_fill_num    = regs[REG_FILL_NUM][FILL_NUM_W-1:0];
	assign initial_fill_num_wr = fill_wr_q | reset | cnt_reset;

	assign channel_tag      = {regs[REG_CHAN_TAG][15:3], ch_addr}; // low bits from jumpers
	assign num_muon_bursts  = regs[REG_MUON_BURSTS][BURST_W-1:0];
	assign num_laser_bursts = regs[REG_LASER_BURSTS][BURST_W-1:0];
	assign num_ped_bursts   = regs[REG_PED_BURSTS][BURST_W-1:0];
	assign genreg_addr_ctrl = regs[REG_GENREG_ADDR];
	assign genreg_wr_data   = regs[REG_GENREG_WDATA];
	assign delay_tap        = regs[REG_DELAY_TAP][TAP_W-1:0];  // same tap on every lane
	assign num_waveforms    = regs[REG_NUM_WAVEFORMS][WAVEFORM_W-1:0];
	assign waveform_gap     = regs[REG_WAVEFORM_GAP][GAP_W-1:0];

	assign taps_ext = TAPS_PAD_W'(current_taps);

	// readback source, narrow fields zero extended
	always_comb begin
		case (sel)
			REG_FILL_NUM:      rd_value = DATA_W'(fill_num);
			REG_CHAN_TAG:      rd_value = DATA_W'(channel_tag);
			REG_MUON_BURSTS:   rd_value = DATA_W'(num_muon_bursts);
			REG_LASER_BURSTS:  rd_value = DATA_W'(num_laser_bursts);
			REG_PED_BURSTS:    rd_value = DATA_W'(num_ped_bursts);
			REG_GENREG_RDATA:  rd_value = genreg_rd_data;
			REG_DELAY_TAP:     rd_value = DATA_W'(delay_tap);
			REG_CUR_TAP_LO:    rd_value = DATA_W'(taps_ext[24:0]);
			REG_CUR_TAP_MID:   rd_value = DATA_W'(taps_ext[49:25]);
			REG_CUR_TAP_HI:    rd_value = DATA_W'(taps_ext[74:50]);
			REG_DELAY_ERR:     rd_value = DATA_W'(delay_error);
			REG_NUM_WAVEFORMS: rd_value = DATA_W'(num_waveforms);
			REG_WAVEFORM_GAP:  rd_value = DATA_W'(waveform_gap);
			default:           rd_value = regs[sel]; // full-width scratch and genreg words
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			tx_data <= '0;
		else if (rd_en)
			tx_data <= rd_value; // held until the next read
	end

endmodule

// ==== acq_controller.sv ====
//////////////////////////////////////////////////
// Acquisition controller
// turns a trigger into waveforms of sample bursts
// separated by programmable gaps
//////////////////////////////////////////////////
`timescale 1ns/1ps

module acq_controller (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           trigger,
	input  wfd_pkg::fill_type_e            fill_type,
	input  logic [wfd_pkg::BURST_W-1:0]    num_muon_bursts,
	input  logic [wfd_pkg::BURST_W-1:0]    num_laser_bursts,
	input  logic [wfd_pkg::BURST_W-1:0]    num_ped_bursts,
	input  logic [wfd_pkg::WAVEFORM_W-1:0] num_waveforms,
	input  logic [wfd_pkg::GAP_W-1:0]      waveform_gap,
	input  logic                           burst_last,
	input  logic                           gap_last,
	output logic                           load_waveform,
	output logic                           start_gap,
	output logic                           burst_strobe,
	output logic                           busy,
	output logic                           fill_done,
	output logic [wfd_pkg::BURST_W-1:0]    burst_count
);
	import wfd_pkg::*;

	acq_state_e            state;
	fill_type_e            type_q;   // fill type of the running fill
	fill_type_e            type_sel;
	logic [WAVEFORM_W-1:0] wf_left;  // waveforms left, current one included
	logic                  start_ok; // trigger with work to do
	logic                  wf_end;   // last burst of a waveform
	logic                  fill_end; // last burst of the fill
	logic                  gap_zero;

	// type is taken live in idle, then held for the whole fill
	assign type_sel = (state == ACQ_IDLE) ? fill_type : type_q;

	always_comb begin
		case (type_sel)
			FILL_MUON:  burst_count = num_muon_bursts;
			FILL_LASER: burst_count = num_laser_bursts;
			FILL_PED:   burst_count = num_ped_bursts;
			default:    burst_count = '0; // unknown type, empty fill
		endcase
	end

	assign start_ok = (state == ACQ_IDLE) && trigger &&
		(burst_count != '0) && (num_waveforms != '0);
	assign wf_end   = (state == ACQ_BURST) && burst_last;
	assign fill_end = wf_end && (wf_left == WAVEFORM_W'(1));
	assign gap_zero = (waveform_gap == '0);

	assign load_waveform = start_ok || (wf_end && !fill_end && gap_zero) ||
		((state == ACQ_GAP) && gap_last);
	assign start_gap     = wf_end && !fill_end && !gap_zero;

	assign burst_strobe = (state == ACQ_BURST);
	assign busy         = (state != ACQ_IDLE);
	assign fill_done    = (state == ACQ_DONE);

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= ACQ_IDLE;
			wf_left <= '0;
		end else begin
			case (state)
				ACQ_IDLE: if (trigger) begin
					state   <= start_ok ? ACQ_BURST : ACQ_DONE; // zero counts end at once
					wf_left <= num_waveforms;
				end
				ACQ_BURST: begin
					if (wf_end)
						wf_left <= wf_left - 1'b1;
					if (fill_end)
						state <= ACQ_DONE;
					else if (start_gap)
						state <= ACQ_GAP; // zero gap stays in burst
				end
				ACQ_GAP: if (gap_last)
					state <= ACQ_BURST;
				default: state <= ACQ_IDLE; // done lasts one cycle
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == ACQ_IDLE) && trigger)
			type_q <= fill_type;
	end

endmodule

// ==== delay_tap_reset.sv ====
//////////////////////////////////////////////////
// ADC input delay reset
// pulses the delay reset on a tap change, then
// checks the tap values reported by every lane
//////////////////////////////////////////////////
`timescale 1ns/1ps

module delay_tap_reset #(
	parameter int NUM_LANES          = 13,
	parameter int DELAY_RESET_CYCLES = 4
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [wfd_pkg::TAP_W-1:0]           delay_tap,     // requested tap
	input  logic [NUM_LANES*wfd_pkg::TAP_W-1:0] current_taps,  // taps read back per lane
	output logic                                delay_data_reset,
	output logic                                delay_error
);
	import wfd_pkg::*;

	localparam int CNT_W = $clog2(DELAY_RESET_CYCLES + 1);

	logic [TAP_W-1:0] tap_q;     // tap seen last cycle
	logic [CNT_W-1:0] pulse_cnt; // remaining reset cycles
	logic             check_q;   // first cycle after the pulse
	logic             mismatch;

	always_comb begin
		mismatch = 1'b0;
		for (int i = 0; i < NUM_LANES; i++)
			if (current_taps[i*TAP_W +: TAP_W] != delay_tap)
				mismatch = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			tap_q       <= TAP_W'(DEF_DELAY_TAP); // no pulse for the default tap
			pulse_cnt   <= '0;
			check_q     <= 1'b0;
			delay_error <= 1'b0;
		end else begin
			tap_q <= delay_tap;
			if (delay_tap != tap_q)
				pulse_cnt <= CNT_W'(DELAY_RESET_CYCLES); // a new change restarts the pulse
			else if (pulse_cnt != '0)
				pulse_cnt <= pulse_cnt - 1'b1;
			check_q <= (pulse_cnt == CNT_W'(1)) && (delay_tap == tap_q);
			if (check_q)
				delay_error <= mismatch; // held until the next check
		end
	end

	assign delay_data_reset = (pulse_cnt != '0);

endmodule

// ==== fill_counter.sv ====
//////////////////////////////////////////////////
// Fill counter
// numbers the fills, reloadable from the host
//////////////////////////////////////////////////
`timescale 1ns/1ps

module fill_counter (
	input  logic                           clk,
	input  logic                           reset,
	input  logic [wfd_pkg::FILL_NUM_W-1:0] initial_fill_num,
	input  logic                           initial_fill_num_wr,
	input  logic                           fill_done,
	output logic [wfd_pkg::FILL_NUM_W-1:0] fill_num
);
	import wfd_pkg::*;

	always_ff @(posedge clk) begin
		if (reset)
			fill_num <= FILL_NUM_W'(DEF_FILL_NUM);
		else if (initial_fill_num_wr)
			fill_num <= initial_fill_num; // load beats a fill end
		else if (fill_done)
			fill_num <= fill_num + 1'b1;
	end

endmodule

// ==== burst_counter.sv ====
//////////////////////////////////////////////////
// Burst and gap counters
// two loadable down-counters for the acquisition FSM
//////////////////////////////////////////////////
`timescale 1ns/1ps

module burst_counter (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [wfd_pkg::BURST_W-1:0] burst_count,   // bursts per waveform
	input  logic [wfd_pkg::GAP_W-1:0]   waveform_gap,  // idle cycles between waveforms
	input  logic                        load_waveform,
	input  logic                        start_gap,
	output logic                        burst_last,
	output logic                        gap_last
);
	import wfd_pkg::*;

	logic [BURST_W-1:0] burst_cnt; // bursts left after this one
	logic [GAP_W-1:0]   gap_cnt;   // gap cycles left after this one

	// both run down to zero after a load and rest there
	always_ff @(posedge clk) begin
		if (reset)
			burst_cnt <= '0;
		else if (load_waveform)
			burst_cnt <= (burst_count == '0) ? '0 : burst_count - 1'b1;
		else if (burst_cnt != '0)
			burst_cnt <= burst_cnt - 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset)
			gap_cnt <= '0;
		else if (start_gap)
			gap_cnt <= (waveform_gap == '0) ? '0 : waveform_gap - 1'b1; // zero gap ends at once
		else if (gap_cnt != '0)
			gap_cnt <= gap_cnt - 1'b1;
	end

	assign burst_last = (burst_cnt == '0);
	assign gap_last   = (gap_cnt == '0);

endmodule

// ==== wfd_pkg.sv ====
//////////////////////////////////////////////////
// Digitizer channel shared definitions
// widths, register map, reset defaults and enums
//////////////////////////////////////////////////
package wfd_pkg;

	localparam int DATA_W     = 32; // host register width
	localparam int REG_ADDR_W = 5;  // 32 registers

	// register map
	localparam logic [REG_ADDR_W-1:0] REG_FILL_NUM      = 5'd0;
	localparam logic [REG_ADDR_W-1:0] REG_CHAN_TAG      = 5'd1;
	localparam logic [REG_ADDR_W-1:0] REG_MUON_BURSTS   = 5'd2;
	localparam logic [REG_ADDR_W-1:0] REG_LASER_BURSTS  = 5'd3;
	localparam logic [REG_ADDR_W-1:0] REG_PED_BURSTS    = 5'd4;
	localparam logic [REG_ADDR_W-1:0] REG_GENREG_ADDR   = 5'd5;
	localparam logic [REG_ADDR_W-1:0] REG_GENREG_WDATA  = 5'd6;
	localparam logic [REG_ADDR_W-1:0] REG_GENREG_RDATA  = 5'd7;  // read only
	localparam logic [REG_ADDR_W-1:0] REG_DELAY_TAP     = 5'd8;
	localparam logic [REG_ADDR_W-1:0] REG_CUR_TAP_LO    = 5'd9;  // read only, lanes 0-4
	localparam logic [REG_ADDR_W-1:0] REG_CUR_TAP_MID   = 5'd10; // read only, lanes 5-9
	localparam logic [REG_ADDR_W-1:0] REG_CUR_TAP_HI    = 5'd11; // read only, lanes 10-12
	localparam logic [REG_ADDR_W-1:0] REG_DELAY_ERR     = 5'd12; // read only
	localparam logic [REG_ADDR_W-1:0] REG_NUM_WAVEFORMS = 5'd14;
	localparam logic [REG_ADDR_W-1:0] REG_WAVEFORM_GAP  = 5'd15;

	// non-zero reset values
	localparam logic [DATA_W-1:0] DEF_FILL_NUM      = 32'd1;
	localparam logic [DATA_W-1:0] DEF_MUON_BURSTS   = 32'd70000;
	localparam logic [DATA_W-1:0] DEF_DELAY_TAP     = 32'd14;
	localparam logic [DATA_W-1:0] DEF_NUM_WAVEFORMS = 32'd1;

	// setting field widths
	localparam int FILL_NUM_W = 24;
	localparam int BURST_W    = 23;
	localparam int WAVEFORM_W = 12;
	localparam int GAP_W      = 22;
	localparam int TAP_W      = 5;  // per ADC lane

	typedef enum logic [1:0] {
		FILL_MUON  = 2'd0,
		FILL_LASER = 2'd1,
		FILL_PED   = 2'd2
	} fill_type_e;

	typedef enum logic [1:0] {
		ACQ_IDLE  = 2'd0,
		ACQ_BURST = 2'd1, // one burst strobe per cycle
		ACQ_GAP   = 2'd2, // dead time between waveforms
		ACQ_DONE  = 2'd3  // fill_done cycle
	} acq_state_e;

endpackage
